/* common/synth_macros.svh */
// Shared widths and block ids for the synthesizer DMA
// Credit count and register reset values
`ifndef SYNTH_MACROS_SVH
`define SYNTH_MACROS_SVH

// Bus and address widths
`define SYNTH_BUS_WIDTH         32
`define SYNTH_DMA_ADRS_WIDTH    16
`define SYNTH_RAM_ADRS_WIDTH    8

// Block ids in address bits 23:16
`define SYNTH_CSR_BLOCK         8'h04
`define SYNTH_RAM_BLOCK         8'h05

// Address bit that marks a bus write
`define SYNTH_WRITE_BIT         30

// Output stream credits granted after reset
`define SYNTH_CREDITS           4

// Register reset values
`define SYNTH_DMA_END_INIT      255
`define SYNTH_AMP_INIT          255

`endif

/* common/synthPkg.sv */
// Synthesizer DMA shared types
// Bus cycle, DMA settings, amplitude set, sample word
// DMA state enum
`default_nettype none

`include "synth_macros.svh"

package synthPkg;

	//----------------------------------------------------------
	// Bus
	//----------------------------------------------------------
	// One bus cycle, write flagged by an address bit
	typedef struct packed {
		logic [`SYNTH_BUS_WIDTH-1:0] wd;
		logic [`SYNTH_BUS_WIDTH-1:0] adrs;
	} usiReq_t;

	//----------------------------------------------------------
	// DMA and mixer settings
	//----------------------------------------------------------
	// Walk range and stride, plus auto cycle mode
	typedef struct packed {
		logic [`SYNTH_DMA_ADRS_WIDTH-1:0] adrsStart;
		logic [`SYNTH_DMA_ADRS_WIDTH-1:0] adrsEnd;
		logic [`SYNTH_DMA_ADRS_WIDTH-1:0] adrsAdd;
		logic                             cycle;
	} dmaCfg_t;

	// Channel 1 amplitude in the low byte
	typedef struct packed {
		logic [3:0][7:0] amp;
	} ampSet_t;

	// Four signed 8-bit samples, channel 1 in the low byte
	typedef struct packed {
		logic [3:0][7:0] ch;
	} sampleWord_t;

	// DMA sequencer states
	typedef enum logic [1:0] {
		IDLE,
		RUN,
		STALL,
		DONE
	} dmaState_e;

endpackage

`default_nettype wire

/* verilog/SynthesizerCsr.sv */
// Control and status registers of the synthesizer
// DMA enable, cycle, start, end and add registers
// Channel amplitudes and registered bus read mux
`timescale 1ns/1ps
`default_nettype none

`include "synth_macros.svh"

module SynthesizerCsr
	import synthPkg::*;
(
	input  wire                         iSCLK,
	input  wire                         iSRST,
	input  wire usiReq_t                busReq,
	input  wire                         dmaDone,
	input  wire [3:0]                   playMask,
	output logic [`SYNTH_BUS_WIDTH-1:0] busRd,
	output logic                        dmaEnable,
	output dmaCfg_t                     dmaCfg,
	output ampSet_t                     amps
);

	// Register offsets
	localparam logic [7:0] OffEnable = 8'h04;
	localparam logic [7:0] OffCycle  = 8'h08;
	localparam logic [7:0] OffStart  = 8'h0C;
	localparam logic [7:0] OffEnd    = 8'h10;
	localparam logic [7:0] OffAdd    = 8'h14;
	localparam logic [7:0] OffAmp    = 8'h60;
	localparam logic [7:0] OffPlay   = 8'h84;

	// Stride after reset
	localparam logic [`SYNTH_DMA_ADRS_WIDTH-1:0] AddInit = 1;

	logic        csrWrite;
	logic [15:0] wrOffset;

	// Write strobe for this block
	assign csrWrite = busReq.adrs[`SYNTH_WRITE_BIT]
		&& (busReq.adrs[23:16] == `SYNTH_CSR_BLOCK);
	assign wrOffset = busReq.adrs[15:0];

	//----------------------------------------------------------
	// Register writes
	//----------------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			dmaEnable        <= 1'b0;
			dmaCfg.cycle     <= 1'b0;
			dmaCfg.adrsStart <= '0;
			dmaCfg.adrsEnd   <= `SYNTH_DMA_END_INIT;
			dmaCfg.adrsAdd   <= AddInit;
			amps             <= {4{8'(`SYNTH_AMP_INIT)}};
		end
		else
		begin
			// End of walk reloads enable from cycle mode, over any bus write
			if (dmaDone)
				dmaEnable <= dmaCfg.cycle;
			else if (csrWrite && (wrOffset == 16'(OffEnable)))
				dmaEnable <= busReq.wd[0];

			if (csrWrite)
			begin
				case (wrOffset)
					16'(OffCycle): dmaCfg.cycle     <= busReq.wd[0];
					16'(OffStart): dmaCfg.adrsStart <= busReq.wd[`SYNTH_DMA_ADRS_WIDTH-1:0];
					16'(OffEnd):   dmaCfg.adrsEnd   <= busReq.wd[`SYNTH_DMA_ADRS_WIDTH-1:0];
					16'(OffAdd):   dmaCfg.adrsAdd   <= busReq.wd[`SYNTH_DMA_ADRS_WIDTH-1:0];
					// All four amplitudes in one word
					16'(OffAmp):   amps             <= busReq.wd;
					default:       ;
				endcase
			end
		end
	end

	//----------------------------------------------------------
	// Register reads
	//----------------------------------------------------------
	// Low 8 address bits only, fields zero-extended
	always_ff @(posedge iSCLK)
	begin
		case (busReq.adrs[7:0])
			OffEnable: busRd <= `SYNTH_BUS_WIDTH'(dmaEnable);
			OffCycle:  busRd <= `SYNTH_BUS_WIDTH'(dmaCfg.cycle);
			OffStart:  busRd <= `SYNTH_BUS_WIDTH'(dmaCfg.adrsStart);
			OffEnd:    busRd <= `SYNTH_BUS_WIDTH'(dmaCfg.adrsEnd);
			OffAdd:    busRd <= `SYNTH_BUS_WIDTH'(dmaCfg.adrsAdd);
			OffAmp:    busRd <= amps;
			// Play status from the top
			OffPlay:   busRd <= `SYNTH_BUS_WIDTH'(playMask);
			// Unmapped offset echoes write data
			default:   busRd <= busReq.wd;
		endcase
	end

endmodule

`default_nettype wire

/* dma/DmaCtrlFsm.sv */
// DMA sequencer FSM
// Output stream credit counter
// Address load/step and RAM read issue
`timescale 1ns/1ps
`default_nettype none

`include "synth_macros.svh"

module DmaCtrlFsm
	import synthPkg::*;
(
	input  wire  iSCLK,
	input  wire  iSRST,
	input  wire  dmaEnable,
	input  wire  atEnd,
	input  wire  creditReturn,
	output logic load,
	output logic step,
	output logic rdEn,
	output logic dmaDone
);

	localparam int CntWidth = $clog2(`SYNTH_CREDITS + 1);

	dmaState_e             state;
	dmaState_e             stateNext;
	logic [CntWidth-1:0]   creditCnt;
	logic                  haveCredit;

	assign haveCredit = (creditCnt != '0);

	//----------------------------------------------------------
	// Next state and strobes
	//----------------------------------------------------------
	always_comb
	begin
		stateNext = state;
		load      = 1'b0;
		step      = 1'b0;
		rdEn      = 1'b0;
		dmaDone   = 1'b0;
		case (state)
			IDLE:
			begin
				// Start address loads while still idle
				if (dmaEnable)
				begin
					load      = 1'b1;
					stateNext = RUN;
				end
			end
			RUN:
			begin
				if (!dmaEnable)
					stateNext = IDLE;
				else if (haveCredit)
				begin
					rdEn = 1'b1;
					// Last read skips the step
					if (atEnd)
						stateNext = DONE;
					else
						step = 1'b1;
				end
				else
					stateNext = STALL;
			end
			STALL:
			begin
				// Wait here until the sink hands back a credit
				if (!dmaEnable)
					stateNext = IDLE;
				else if (haveCredit)
					stateNext = RUN;
			end
			DONE:
			begin
				dmaDone   = 1'b1;
				stateNext = IDLE;
			end
			default: stateNext = IDLE;
		endcase
	end

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
			state <= IDLE;
		else
			state <= stateNext;
	end

	//----------------------------------------------------------
	// Credit counter
	//----------------------------------------------------------
	// Return and issue may land in the same cycle
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
			creditCnt <= CntWidth'(`SYNTH_CREDITS);
		else
			creditCnt <= creditCnt + CntWidth'(creditReturn) - CntWidth'(rdEn);
	end

endmodule

`default_nettype wire

/* dma/DmaAdrsCounter.sv */
// DMA address counter
// Start load, stride step and end compare
`timescale 1ns/1ps
`default_nettype none

`include "synth_macros.svh"

module DmaAdrsCounter
	import synthPkg::*;
(
	input  wire                             iSCLK,
	input  wire                             iSRST,
	input  wire                             load,
	input  wire                             step,
	input  wire dmaCfg_t                    dmaCfg,
	output logic [`SYNTH_DMA_ADRS_WIDTH-1:0] adrs,
	output logic                            atEnd
);

	// Load wins if both strobes are seen
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
			adrs <= '0;
		else if (load)
			adrs <= dmaCfg.adrsStart;
		else if (step)
			adrs <= adrs + dmaCfg.adrsAdd;
	end

	// At or past the end address
	assign atEnd = (adrs >= dmaCfg.adrsEnd);

endmodule

`default_nettype wire

/* verilog/SampleRam.sv */
// Sample RAM, 256 words of four channel samples
// Bus write port, registered DMA read port
`timescale 1ns/1ps
`default_nettype none

`include "synth_macros.svh"

module SampleRam
	import synthPkg::*;
(
	input  wire                             iSCLK,
	input  wire                             iSRST,
	input  wire usiReq_t                    busReq,
	input  wire                             rdEn,
	input  wire [`SYNTH_RAM_ADRS_WIDTH-1:0] rdAdrs,
	output sampleWord_t                     rdData,
	output logic                            rdValid
);

	sampleWord_t mem [2**`SYNTH_RAM_ADRS_WIDTH];
	logic        ramWrite;

	// Word index from address bits 9:2
	assign ramWrite = busReq.adrs[`SYNTH_WRITE_BIT]
		&& (busReq.adrs[23:16] == `SYNTH_RAM_BLOCK);

	always_ff @(posedge iSCLK)
	begin
		if (ramWrite)
			mem[busReq.adrs[`SYNTH_RAM_ADRS_WIDTH+1:2]] <= busReq.wd;
		// Read data one cycle after the request
		if (rdEn)
			rdData <= mem[rdAdrs];
	end

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
			rdValid <= 1'b0;
		else
			rdValid <= rdEn;
	end

endmodule

`default_nettype wire

/* verilog/SampleMixer.sv */
// Four-channel sample mixer
// Amplitude scaling, play-mask gating, summing
// Registered 16-bit output sample
`timescale 1ns/1ps
`default_nettype none

module SampleMixer
	import synthPkg::*;
(
	input  wire              iSCLK,
	input  wire              iSRST,
	input  wire sampleWord_t rdData,
	input  wire              rdValid,
	input  wire ampSet_t     amps,
	input  wire [3:0]        playMask,
	output logic [15:0]      sample,
	output logic             sampleValid
);

	logic signed [16:0] chProd   [4];
	logic signed [8:0]  chScaled [4];
	logic signed [10:0] mixSum;

	//----------------------------------------------------------
	// Scale and sum
	//----------------------------------------------------------
	always_comb
	begin
		mixSum = '0;
		for (int i = 0; i < 4; i++)
		begin
			// Signed sample times unsigned amplitude
			chProd[i] = $signed(rdData.ch[i]) * $signed({1'b0, amps.amp[i]});
			// Muted channel adds nothing
			chScaled[i] = playMask[i] ? 9'(chProd[i] >>> 8) : 9'sd0;
			mixSum = mixSum + chScaled[i];
		end
	end

	// Sum sign-extended into the output word
	always_ff @(posedge iSCLK)
	begin
		if (rdValid)
			sample <= 16'(mixSum);
	end

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
			sampleValid <= 1'b0;
		else
			sampleValid <= rdValid;
	end

endmodule

`default_nettype wire

/* verilog/SynthDmaTop.sv */
// Sample playback DMA top level
// Register block, DMA FSM, address counter
// Sample RAM, mixer and credit-based output stream
`timescale 1ns/1ps
`default_nettype none

`include "synth_macros.svh"

module SynthDmaTop
	import synthPkg::*;
(
	input  wire                         iSCLK,
	input  wire                         iSRST,
	input  wire usiReq_t                busReq,
	input  wire [3:0]                   playMask,
	input  wire                         creditReturn,
	output logic [`SYNTH_BUS_WIDTH-1:0] busRd,
	output logic [15:0]                 sample,
	output logic                        sampleValid
);

	// Settings from the register block
	dmaCfg_t                          dmaCfg;
	ampSet_t                          amps;
	logic                             dmaEnable;
	logic                             dmaDone;
	// Counter handshake
	logic                             load;
	logic                             step;
	logic [`SYNTH_DMA_ADRS_WIDTH-1:0] adrs;
	logic                             atEnd;
	// RAM read path
	logic                             rdEn;
	sampleWord_t                      rdData;
	logic                             rdValid;

	SynthesizerCsr csr0 (
		.iSCLK     (iSCLK),
		.iSRST     (iSRST),
		.busReq    (busReq),
		.dmaDone   (dmaDone),
		.playMask  (playMask),
		.busRd     (busRd),
		.dmaEnable (dmaEnable),
		.dmaCfg    (dmaCfg),
		.amps      (amps)
	);

	DmaCtrlFsm fsm0 (
		.iSCLK        (iSCLK),
		.iSRST        (iSRST),
		.dmaEnable    (dmaEnable),
		.atEnd        (atEnd),
		.creditReturn (creditReturn),
		.load         (load),
		.step         (step),
		.rdEn         (rdEn),
		.dmaDone      (dmaDone)
	);

	DmaAdrsCounter adrsCnt0 (
		.iSCLK  (iSCLK),
		.iSRST  (iSRST),
		.load   (load),
		.step   (step),
		.dmaCfg (dmaCfg),
		.adrs   (adrs),
		.atEnd  (atEnd)
	);

	// RAM index is the low part of the DMA address
	SampleRam ram0 (
		.iSCLK   (iSCLK),
		.iSRST   (iSRST),
		.busReq  (busReq),
		.rdEn    (rdEn),
		.rdAdrs  (adrs[`SYNTH_RAM_ADRS_WIDTH-1:0]),
		.rdData  (rdData),
		.rdValid (rdValid)
	);

	SampleMixer mixer0 (
		.iSCLK       (iSCLK),
		.iSRST       (iSRST),
		.rdData      (rdData),
		.rdValid     (rdValid),
		.amps        (amps),
		.playMask    (playMask),
		.sample      (sample),
		.sampleValid (sampleValid)
	);

endmodule

`default_nettype wire

/* tests/SynthDmaChecker.sv */
// Testbench checker for the synthesizer DMA
// Registered bus read compare, in-order stream sample compare
// Error and check counters
`timescale 1ns/1ps
`default_nettype none

module SynthDmaChecker
(
	input  wire        iSCLK,
	input  wire        iSRST,
	input  wire [31:0] busRd,
	input  wire [15:0] sample,
	input  wire        sampleValid,
	input  wire        rdCheck,
	input  wire [7:0]  rdOffset,
	input  wire [31:0] rdExp,
	input  wire        expPush,
	input  wire [15:0] expSample,
	input  wire [3:0]  testId,
	output int         pending,
	output int         checkCount,
	output int         errorCount
);

	// Expected beats, test id in the top nibble
	logic [19:0] expQ [$];
	int          pushCount;
	int          seenCount;
	// Read request one cycle back
	logic        rdCheckQ;
	logic [7:0]  rdOffsetQ;
	logic [31:0] rdExpQ;
	logic [3:0]  rdTestQ;

	function automatic string testName(input logic [3:0] id);
		case (id)
			4'd1:    return "reset and registers";
			4'd2:    return "one-shot playback";
			4'd3:    return "stride and amplitude";
			4'd4:    return "credit back-pressure";
			4'd5:    return "cycle mode";
			default: return "unnamed test";
		endcase
	endfunction

	assign pending = pushCount - seenCount;

	initial
	begin
		pushCount  = 0;
		seenCount  = 0;
		checkCount = 0;
		errorCount = 0;
		rdCheckQ   = 1'b0;
	end

	always @(posedge iSCLK)
	begin
		logic [19:0] head;
		if (iSRST)
			rdCheckQ <= 1'b0;
		else
		begin
			if (expPush)
			begin
				expQ.push_back({testId, expSample});
				pushCount++;
			end

			//----------------------------------------------------
			// Stream beats in issue order
			//----------------------------------------------------
			if (sampleValid)
			begin
				if (expQ.size() == 0)
				begin
					errorCount++;
					$display("A stream sample 0x%04h arrived when none was expected in %s",
						sample, testName(testId));
				end
				else
				begin
					head = expQ.pop_front();
					seenCount++;
					checkCount++;
					if (sample !== head[15:0])
					begin
						errorCount++;
						$display("Error in %s: sample expected 0x%04h actual 0x%04h",
							testName(head[19:16]), head[15:0], sample);
					end
				end
			end

			// busRd now holds the value for last cycle's address
			if (rdCheckQ)
			begin
				checkCount++;
				if (busRd !== rdExpQ)
				begin
					errorCount++;
					$display("Error in %s: read 0x%02h expected 0x%08h actual 0x%08h",
						testName(rdTestQ), rdOffsetQ, rdExpQ, busRd);
				end
			end
			rdCheckQ  <= rdCheck;
			rdOffsetQ <= rdOffset;
			rdExpQ    <= rdExp;
			rdTestQ   <= testId;
		end
	end

endmodule

`default_nettype wire

/* tests/SynthDmaTb.sv */
// Testbench top for the sample playback DMA
// Clock, reset, vector-driven bus and sample expectations
// LFSR-timed credit returns from the stream sink
`timescale 1ns/1ps
`default_nettype none

`include "synth_macros.svh"

module SynthDmaTb
	import synthPkg::*;
();

	localparam int MaxVectors = 128;
	localparam int DrainLimit = 4000;

	logic                        iSCLK;
	logic                        iSRST;
	usiReq_t                     busReq;
	logic [3:0]                  playMask;
	logic                        creditReturn;
	logic [`SYNTH_BUS_WIDTH-1:0] busRd;
	logic [15:0]                 sample;
	logic                        sampleValid;

	// Checker side
	logic        rdCheck;
	logic [7:0]  rdOffset;
	logic [31:0] rdExp;
	logic        expPush;
	logic [15:0] expSample;
	logic [3:0]  testId;
	int          pending;
	int          checkCount;
	int          errorCount;

	// Sink credit state
	logic        allowCredit;
	int          owed;
	logic [15:0] lfsr;

	// op, test, address, data, expected
	logic [103:0] vecMem [MaxVectors];
	int           runFailCount;
	int           vecCount;
	logic         timedOut;

	//------------------------------------------------------------
	// Clock
	//------------------------------------------------------------
	initial
	begin
		iSCLK = 1'b0;
		forever #10 iSCLK = ~iSCLK;
	end

	SynthDmaTop dut0 (
		.iSCLK        (iSCLK),
		.iSRST        (iSRST),
		.busReq       (busReq),
		.playMask     (playMask),
		.creditReturn (creditReturn),
		.busRd        (busRd),
		.sample       (sample),
		.sampleValid  (sampleValid)
	);

	SynthDmaChecker chk0 (
		.iSCLK       (iSCLK),
		.iSRST       (iSRST),
		.busRd       (busRd),
		.sample      (sample),
		.sampleValid (sampleValid),
		.rdCheck     (rdCheck),
		.rdOffset    (rdOffset),
		.rdExp       (rdExp),
		.expPush     (expPush),
		.expSample   (expSample),
		.testId      (testId),
		.pending     (pending),
		.checkCount  (checkCount),
		.errorCount  (errorCount)
	);

	// 16-bit Fibonacci LFSR, taps 16 14 13 11
	function automatic logic [15:0] nextLfsr(input logic [15:0] state);
		logic feedback;
		feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
		return {state[14:0], feedback};
	endfunction

	//------------------------------------------------------------
	// Stream sink
	//------------------------------------------------------------
	// One credit owed per beat, handed back on LFSR-chosen cycles
	always @(negedge iSCLK)
	begin
		int owedNext;
		owedNext = owed + (sampleValid ? 1 : 0);
		if (iSRST)
		begin
			owed         <= 0;
			creditReturn <= 1'b0;
		end
		else if (allowCredit && owedNext > 0)
		begin
			lfsr = nextLfsr(lfsr);
			creditReturn <= lfsr[0];
			owed         <= owedNext - (lfsr[0] ? 1 : 0);
		end
		else
		begin
			creditReturn <= 1'b0;
			owed         <= owedNext;
		end
	end

	//------------------------------------------------------------
	// Bus and expectation drivers
	//------------------------------------------------------------
	task automatic busWrite(input logic [31:0] adrs, input logic [31:0] data);
		busReq.adrs = adrs;
		busReq.wd   = data;
		@(negedge iSCLK);
		busReq = '0;
	endtask

	// Checker compares busRd two edges later
	task automatic busRead(input logic [31:0] adrs, input logic [31:0] data,
		input logic [31:0] exp);
		busReq.adrs = adrs;
		busReq.wd   = data;
		rdCheck     = 1'b1;
		rdOffset    = adrs[7:0];
		rdExp       = exp;
		@(negedge iSCLK);
		busReq  = '0;
		rdCheck = 1'b0;
	endtask

	task automatic pushSample(input logic [15:0] value);
		expPush   = 1'b1;
		expSample = value;
		@(negedge iSCLK);
		expPush = 1'b0;
	endtask

	// All expected beats seen and, if the sink is returning, all credits back
	task automatic waitDrain();
		int cycles;
		cycles = 0;
		while ((pending != 0 || (allowCredit && owed != 0)) && cycles < DrainLimit)
		begin
			@(negedge iSCLK);
			cycles++;
		end
		if (pending != 0 || (allowCredit && owed != 0))
		begin
			$display("Timeout: the sample stream did not drain during test %0d", testId);
			runFailCount++;
			timedOut = 1'b1;
		end
	endtask

	//------------------------------------------------------------
	// Vector sequencer
	//------------------------------------------------------------
	initial
	begin
		logic [103:0] vec;
		logic [3:0]   op;
		int           idx;
		busReq       = '0;
		playMask     = 4'hF;
		creditReturn = 1'b0;
		rdCheck      = 1'b0;
		rdOffset     = '0;
		rdExp        = '0;
		expPush      = 1'b0;
		expSample    = '0;
		testId       = '0;
		allowCredit  = 1'b1;
		owed         = 0;
		lfsr         = 16'd3;
		runFailCount = 0;
		timedOut     = 1'b0;
		$readmemh("tests/synth_dma_vectors.txt", vecMem);

		iSRST = 1'b1;
		repeat (8) @(negedge iSCLK);
		iSRST = 1'b0;

		idx = 0;
		while (idx < MaxVectors && !timedOut)
		begin
			vec = vecMem[idx];
			op  = vec[103:100];
			// Unread entries or op 0 end the list
			if ($isunknown(op) || op == 4'h0)
				break;
			testId = vec[99:96];
			case (op)
				4'h1: busWrite(vec[95:64], vec[63:32]);
				4'h2: busRead(vec[95:64], vec[63:32], vec[31:0]);
				4'h3: pushSample(vec[15:0]);
				4'h4: playMask = vec[35:32];
				4'h5:
				begin
					allowCredit <= vec[32];
					@(negedge iSCLK);
				end
				4'h6: waitDrain();
				4'h7: repeat (vec[63:32]) @(negedge iSCLK);
				default:
				begin
					$display("Unknown vector op %0h at entry %0d", op, idx);
					runFailCount++;
					break;
				end
			endcase
			idx++;
		end
		vecCount = idx;

		// Let the last register compare land
		repeat (4) @(negedge iSCLK);
		if (vecCount == 0)
		begin
			$display("No vectors were read from the vector file");
			runFailCount++;
		end
		$display("Checks %0d, errors %0d, run failures %0d",
			checkCount, errorCount, runFailCount);
		if (errorCount == 0 && runFailCount == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* tests/synth_dma_vectors.txt */
// op test _ address _ data _ expected; ops: 1 write, 2 read+compare, 3 expected sample,
// 4 play mask, 5 credit returns on/off, 6 wait for stream drain, 7 idle cycles, 0 end
21_00040004_00000000_00000000
21_00040010_00000000_000000FF
21_00040014_00000000_00000001
21_00040060_00000000_FFFFFFFF
11_4004000C_00001234_00000000
21_0004000C_00000000_00001234
11_40040010_000ABCD5_00000000
21_00040010_00000000_0000BCD5
41_00000000_0000000A_00000000
21_00040084_00000000_0000000A
21_00040040_DEADBEEF_DEADBEEF
41_00000000_0000000F_00000000
// sample RAM words 0..7 and 9
12_40050000_05F6140A_00000000
12_40050004_FF017F80_00000000
12_40050008_40404040_00000000
12_4005000C_C0C0C0C0_00000000
12_40050010_1E00CE64_00000000
12_40050014_FCFDFEFF_00000000
12_40050018_04030201_00000000
12_4005001C_7F7F7F7F_00000000
12_40050024_A65AEC32_00000000
// one-shot 0..7, full amplitude, all channels
12_4004000C_00000000_00000000
12_40040010_00000007_00000000
32_00000000_00000000_00000016
32_00000000_00000000_0000FFFD
32_00000000_00000000_000000FC
32_00000000_00000000_0000FF00
32_00000000_00000000_0000004E
32_00000000_00000000_0000FFF6
32_00000000_00000000_00000006
32_00000000_00000000_000001F8
12_40040004_00000001_00000000
62_00000000_00000000_00000000
22_00040004_00000000_00000000
// stride 3 visits 0 3 6 9, channel 3 muted
13_40040014_00000003_00000000
13_40040060_10FF4080_00000000
43_00000000_0000000B_00000000
33_00000000_00000000_0000000A
33_00000000_00000000_0000FFCC
33_00000000_00000000_00000000
33_00000000_00000000_0000000E
13_40040004_00000001_00000000
63_00000000_00000000_00000000
23_00040004_00000000_00000000
23_00040014_00000000_00000003
// back-pressure, four credits then stall
14_40040014_00000001_00000000
14_40040060_FFFFFFFF_00000000
44_00000000_0000000F_00000000
34_00000000_00000000_00000016
34_00000000_00000000_0000FFFD
34_00000000_00000000_000000FC
34_00000000_00000000_0000FF00
54_00000000_00000000_00000000
14_40040004_00000001_00000000
64_00000000_00000000_00000000
74_00000000_0000001E_00000000
24_00040004_00000000_00000001
34_00000000_00000000_0000004E
34_00000000_00000000_0000FFF6
34_00000000_00000000_00000006
34_00000000_00000000_000001F8
54_00000000_00000001_00000000
64_00000000_00000000_00000000
24_00040004_00000000_00000000
// cycle mode over 0..1, stopped by writing enable 0
15_40040010_00000001_00000000
15_40040008_00000001_00000000
35_00000000_00000000_00000016
35_00000000_00000000_0000FFFD
35_00000000_00000000_00000016
35_00000000_00000000_0000FFFD
55_00000000_00000000_00000000
15_40040004_00000001_00000000
65_00000000_00000000_00000000
75_00000000_00000014_00000000
25_00040004_00000000_00000001
25_00040008_00000000_00000001
15_40040004_00000000_00000000
55_00000000_00000001_00000000
75_00000000_00000028_00000000
25_00040004_00000000_00000000
00_00000000_00000000_00000000

/* synthDma.f */
+incdir+common
common/synthPkg.sv
verilog/SynthesizerCsr.sv
dma/DmaCtrlFsm.sv
dma/DmaAdrsCounter.sv
verilog/SampleRam.sv
verilog/SampleMixer.sv
verilog/SynthDmaTop.sv
tests/SynthDmaChecker.sv
tests/SynthDmaTb.sv

/* Bender.yml */
package:
  name: synthDma

sources:
  - include_dirs:
      - common
    files:
      - common/synthPkg.sv
      - verilog/SynthesizerCsr.sv
      - dma/DmaCtrlFsm.sv
      - dma/DmaAdrsCounter.sv
      - verilog/SampleRam.sv
      - verilog/SampleMixer.sv
      - verilog/SynthDmaTop.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/SynthDmaChecker.sv
      - tests/SynthDmaTb.sv
